// ==== rtl/flash_emu_cfg.svh ====
// FLASH_ADDR_BITS must stay 24 because the address union is built from exactly three bytes
`ifndef FLASH_EMU_CFG_SVH
`define FLASH_EMU_CFG_SVH

// number of chip selects on the shared bus
`define FLASH_NUM_DEVICES 4

// byte address width seen by the host
`define FLASH_ADDR_BITS 24

// plain read opcode, the only command that touches memory
`define FLASH_CMD_READ 8'h03

// sent when no reply byte is queued
// also sent for every unsupported command
`define FLASH_IDLE_BYTE 8'hFF

`endif

// ==== rtl/flash_emu_pkg.sv ====
// flash_addr_t only works for a 24-bit address split into three whole bytes
`include "flash_emu_cfg.svh"

package flash_emu_pkg;

	// one spi byte
	typedef logic [7:0] byte_t;

	// one word of the 16-bit system memory
	typedef logic [15:0] ram_word_t;

	// address as received, index 2 is the first byte on the wire
	typedef byte_t [2:0] addr_bytes_t;

	// address as the memory sees it
	typedef struct packed {
		// word index into the 16-bit memory
		logic [`FLASH_ADDR_BITS-2:0] word;
		// set selects bits 15:8 of the word
		logic lane;
	} addr_word_t;

	// same 24 bits decoded as bytes or as word plus lane
	// incrementing addr_bytes as one number carries into the word index
	typedef union packed {
		addr_bytes_t addr_bytes;
		addr_word_t addr_word;
	} flash_addr_t;

endpackage

// ==== rtl/spi_byte_if.sv ====
// strobes are one clk wide and rx_data is only complete while rx_strobe is high
`timescale 1ns/1ps

interface spi_byte_if;

	// high while this device is not selected
	logic cs;
	// bits received so far, msb first, zeros in the missing positions
	flash_emu_pkg::byte_t rx_data;
	// first byte after the select, comes with rx_strobe
	logic rx_cmd;
	// whole byte received
	logic rx_strobe;
	// arrival index of the bit just sampled, 0 is the msb
	logic [2:0] rx_bit;
	logic rx_bit_strobe;
	// reply byte for the next byte slot on miso
	logic tx_strobe;
	flash_emu_pkg::byte_t tx_data;

	modport front_end (
		output cs, rx_data, rx_cmd, rx_strobe, rx_bit, rx_bit_strobe,
		input tx_strobe, tx_data
	);

	modport responder (
		input cs, rx_data, rx_cmd, rx_strobe, rx_bit, rx_bit_strobe,
		output tx_strobe, tx_data
	);

endinterface

// ==== rtl/ram_req_if.sv ====
// read_enable is a level held until the single-cycle read_valid comes back
`timescale 1ns/1ps

interface ram_req_if;

	// port lock for the whole read transaction
	logic critical;
	// word address, zero above bit 22
	logic [31:0] addr;
	logic read_enable;
	// shared by all requesters, valid only with read_valid
	flash_emu_pkg::ram_word_t read_data;
	logic read_valid;

	modport requester (
		output critical, addr, read_enable,
		input read_data, read_valid
	);

	modport port (
		input critical, addr, read_enable,
		output read_data, read_valid
	);

endinterface

// ==== rtl/spi_front_end.sv ====
// spi mode 0 only, sck period of 16 clk or more, the lowest-indexed active select wins
`timescale 1ns/1ps
`include "flash_emu_cfg.svh"

module spi_front_end (
	input logic clk,
	input logic reset,
	input logic spi_sck,
	input logic [`FLASH_NUM_DEVICES-1:0] spi_cs_n,
	input logic spi_mosi,
	output logic spi_miso,
	spi_byte_if.front_end bus [`FLASH_NUM_DEVICES-1:0]
);

	// two sync flops plus one history flop for edge detect
	logic [2:0] sck_sync;
	logic [`FLASH_NUM_DEVICES-1:0] cs_meta;
	logic [`FLASH_NUM_DEVICES-1:0] cs_sync;
	logic [1:0] mosi_sync;
	logic sck_rise;
	logic sck_fall;
	// one-hot selected device
	logic [`FLASH_NUM_DEVICES-1:0] sel;
	logic [`FLASH_NUM_DEVICES-1:0] sel_q;
	logic sel_start;
	logic [2:0] bit_cnt;
	logic first_byte;
	flash_emu_pkg::byte_t rx_data;
	flash_emu_pkg::byte_t rx_next;
	logic [2:0] rx_bit;
	logic rx_strobe;
	logic rx_bit_strobe;
	logic rx_cmd;
	// reply bytes from all responders
	logic [`FLASH_NUM_DEVICES-1:0] tx_strobe_v;
	flash_emu_pkg::byte_t tx_data_v [`FLASH_NUM_DEVICES];
	logic tx_strobe_sel;
	flash_emu_pkg::byte_t tx_data_sel;
	// queued reply and the shifter that drives miso
	flash_emu_pkg::byte_t pend_data;
	logic pend_valid;
	flash_emu_pkg::byte_t tx_shift;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sck_sync <= '0;
			cs_meta <= '1;
			cs_sync <= '1;
		end
		else
		begin
			sck_sync <= {sck_sync[1:0], spi_sck};
			cs_meta <= spi_cs_n;
			cs_sync <= cs_meta;
		end
		// mosi delayed to line up with sck_sync[1]
		mosi_sync <= {mosi_sync[0], spi_mosi};
	end

	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];

	// walk down so the lowest active select is kept
	always_comb
	begin
		sel = '0;
		for (int i = `FLASH_NUM_DEVICES - 1; i >= 0; i--)
		begin
			if (!cs_sync[i])
			begin
				sel = '0;
				sel[i] = 1'b1;
			end
		end
	end

	// new device selected or a select after idle
	assign sel_start = (|sel) && (sel != sel_q);

	always_comb
	begin
		tx_strobe_sel = |(tx_strobe_v & sel);
		tx_data_sel = '0;
		for (int i = 0; i < `FLASH_NUM_DEVICES; i++)
		begin
			if (sel[i])
				tx_data_sel = tx_data_v[i];
		end
	end

	// first bit of a byte clears the older bits
	always_comb
	begin
		rx_next = (bit_cnt == 3'd0) ? 8'h00 : rx_data;
		rx_next[3'd7 - bit_cnt] = mosi_sync[1];
	end

	always_ff @(posedge clk)
	begin
		rx_strobe <= 1'b0;
		rx_bit_strobe <= 1'b0;
		rx_cmd <= 1'b0;
		if (reset)
		begin
			sel_q <= '0;
			bit_cnt <= '0;
			first_byte <= 1'b0;
			pend_valid <= 1'b0;
			tx_shift <= `FLASH_IDLE_BYTE;
		end
		else
		begin
			sel_q <= sel;
			if (sel_start)
			begin
				// restart byte framing for the new transaction
				bit_cnt <= '0;
				first_byte <= 1'b1;
				pend_valid <= 1'b0;
				tx_shift <= `FLASH_IDLE_BYTE;
				rx_data <= '0;
			end
			else if (|sel)
			begin
				// mode 0 samples mosi on rising sck
				if (sck_rise)
				begin
					rx_data <= rx_next;
					rx_bit <= bit_cnt;
					rx_bit_strobe <= 1'b1;
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
					begin
						rx_strobe <= 1'b1;
						rx_cmd <= first_byte;
						first_byte <= 1'b0;
					end
				end
				// falling sck after the eighth bit loads the next byte
				if (sck_fall)
				begin
					if (bit_cnt == 3'd0)
					begin
						tx_shift <= pend_valid ? pend_data : `FLASH_IDLE_BYTE;
						pend_valid <= 1'b0;
					end
					else
						tx_shift <= {tx_shift[6:0], 1'b1};
				end
				// latest strobe before the boundary wins
				if (tx_strobe_sel)
				begin
					pend_data <= tx_data_sel;
					pend_valid <= 1'b1;
				end
			end
		end
	end

	// only the selected device sees byte events
	for (genvar i = 0; i < `FLASH_NUM_DEVICES; i++)
	begin : g_dev
		assign bus[i].cs = ~sel[i];
		assign bus[i].rx_data = rx_data;
		assign bus[i].rx_bit = rx_bit;
		assign bus[i].rx_cmd = rx_cmd & sel[i];
		assign bus[i].rx_strobe = rx_strobe & sel[i];
		assign bus[i].rx_bit_strobe = rx_bit_strobe & sel[i];
		assign tx_strobe_v[i] = bus[i].tx_strobe;
		assign tx_data_v[i] = bus[i].tx_data;
	end

	// miso idles high when nobody is selected
	assign spi_miso = (|sel) ? tx_shift[7] : 1'b1;

endmodule

// ==== rtl/flash_read_responder.sv ====
// only opcode 0x03 reads memory, and a byte whose data misses its boundary goes out as 0xff
`timescale 1ns/1ps
`include "flash_emu_cfg.svh"

module flash_read_responder (
	input logic clk,
	input logic reset,
	spi_byte_if.responder bus,
	ram_req_if.requester mem
);

	// byte count within the transaction
	typedef enum logic [2:0] {
		st_idle,
		st_addr_hi,
		st_addr_mid,
		st_addr_lo,
		st_data
	} state_t;

	state_t state;
	flash_emu_pkg::flash_addr_t addr;
	flash_emu_pkg::flash_addr_t addr_next;
	flash_emu_pkg::ram_word_t word_q;
	flash_emu_pkg::ram_word_t word_now;
	logic [`FLASH_ADDR_BITS-2:0] req_word;
	// word_q holds the data for the current fetch
	logic word_ok;
	logic word_here;
	// boundary passed without data, send on return
	logic late;

	function automatic flash_emu_pkg::byte_t pick_byte(
		input flash_emu_pkg::ram_word_t w,
		input logic lane
	);
		return lane ? w[15:8] : w[7:0];
	endfunction

	// full 24-bit increment, carry runs into the upper bytes
	always_comb
	begin
		addr_next.addr_bytes = addr.addr_bytes + 1'b1;
	end

	// returning word counts as present in its own cycle
	assign word_here = word_ok | mem.read_valid;
	assign word_now = mem.read_valid ? mem.read_data : word_q;

	assign mem.addr = 32'(req_word);

	always_ff @(posedge clk)
	begin
		bus.tx_strobe <= 1'b0;
		if (mem.read_valid)
			word_q <= mem.read_data;
		if (reset)
		begin
			state <= st_idle;
			mem.critical <= 1'b0;
			mem.read_enable <= 1'b0;
			word_ok <= 1'b0;
			late <= 1'b0;
		end
		else if (bus.cs)
		begin
			// deselected, give up the port and any fetch
			state <= st_idle;
			mem.critical <= 1'b0;
			mem.read_enable <= 1'b0;
			word_ok <= 1'b0;
			late <= 1'b0;
		end
		else if (bus.rx_cmd)
		begin
			word_ok <= 1'b0;
			late <= 1'b0;
			// lock the memory port as soon as a read starts
			if (bus.rx_data == `FLASH_CMD_READ)
			begin
				state <= st_addr_hi;
				mem.critical <= 1'b1;
			end
			else
			begin
				state <= st_idle;
				mem.critical <= 1'b0;
			end
		end
		else if (state != st_idle)
		begin
			if (mem.read_valid)
			begin
				mem.read_enable <= 1'b0;
				word_ok <= 1'b1;
				late <= 1'b0;
				// missed the boundary, queue the byte now
				if (late)
				begin
					bus.tx_strobe <= 1'b1;
					bus.tx_data <= pick_byte(mem.read_data, addr.addr_word.lane);
				end
			end
			// seventh bit of the last address byte gives all 23 word bits
			if (bus.rx_bit_strobe && bus.rx_bit == 3'd6 && state == st_addr_lo)
			begin
				req_word <= {addr.addr_bytes[2], addr.addr_bytes[1], bus.rx_data[7:1]};
				mem.read_enable <= 1'b1;
				word_ok <= 1'b0;
			end
			// halfway through a data byte, fetch for the following one
			if (bus.rx_bit_strobe && bus.rx_bit == 3'd4 && state == st_data)
			begin
				addr <= addr_next;
				req_word <= addr_next.addr_word.word;
				mem.read_enable <= 1'b1;
				word_ok <= 1'b0;
				late <= 1'b0;
			end
			if (bus.rx_strobe)
			begin
				case (state)
				st_addr_hi:
				begin
					addr.addr_bytes[2] <= bus.rx_data;
					state <= st_addr_mid;
				end
				st_addr_mid:
				begin
					// early fetch opens the memory row, data is not used
					addr.addr_bytes[1] <= bus.rx_data;
					req_word <= {addr.addr_bytes[2], bus.rx_data, 7'd0};
					mem.read_enable <= 1'b1;
					word_ok <= 1'b0;
					state <= st_addr_lo;
				end
				st_addr_lo:
				begin
					addr.addr_bytes[0] <= bus.rx_data;
					state <= st_data;
					// lane comes from the byte just received
					if (word_here)
					begin
						bus.tx_strobe <= 1'b1;
						bus.tx_data <= pick_byte(word_now, bus.rx_data[0]);
					end
					else
						late <= 1'b1;
				end
				default:
				begin
					if (word_here)
					begin
						bus.tx_strobe <= 1'b1;
						bus.tx_data <= pick_byte(word_now, addr.addr_word.lane);
					end
					else
						late <= 1'b1;
				end
				endcase
			end
		end
	end

endmodule

// ==== rtl/ram_port_arbiter.sv ====
// no preemption, so a requester keeps the port until its critical falls
`timescale 1ns/1ps
`include "flash_emu_cfg.svh"

module ram_port_arbiter (
	input logic clk,
	input logic reset,
	ram_req_if.port req [`FLASH_NUM_DEVICES-1:0],
	output logic [31:0] ram_addr,
	output logic ram_read_enable,
	input flash_emu_pkg::ram_word_t ram_read_data,
	input logic ram_read_valid
);

	logic [`FLASH_NUM_DEVICES-1:0] crit_v;
	logic [`FLASH_NUM_DEVICES-1:0] en_v;
	logic [31:0] addr_v [`FLASH_NUM_DEVICES];
	// one-hot owner of the port
	logic [`FLASH_NUM_DEVICES-1:0] grant;
	logic [`FLASH_NUM_DEVICES-1:0] first_crit;

	for (genvar i = 0; i < `FLASH_NUM_DEVICES; i++)
	begin : g_req
		assign crit_v[i] = req[i].critical;
		assign en_v[i] = req[i].read_enable;
		assign addr_v[i] = req[i].addr;
		// data is shared, the valid pulse goes to the owner only
		assign req[i].read_data = ram_read_data;
		assign req[i].read_valid = ram_read_valid & grant[i];
	end

	// lowest set bit of the critical vector
	assign first_crit = crit_v & (~crit_v + 1'b1);

	// hold while the owner stays critical, else hand over
	always_ff @(posedge clk)
	begin
		if (reset)
			grant <= '0;
		else if (!(|(grant & crit_v)))
			grant <= first_crit;
	end

	always_comb
	begin
		ram_addr = '0;
		for (int i = 0; i < `FLASH_NUM_DEVICES; i++)
		begin
			if (grant[i])
				ram_addr = addr_v[i];
		end
	end

	assign ram_read_enable = |(grant & en_v);

endmodule

// ==== rtl/flash_emu_top.sv ====
// memory must answer 1 to 16 clk after ram_read_enable and hold ram_read_data until the next request
`timescale 1ns/1ps
`include "flash_emu_cfg.svh"

module flash_emu_top (
	input logic clk,
	input logic reset,
	// spi bus, one select per emulated device
	input logic spi_sck,
	input logic [`FLASH_NUM_DEVICES-1:0] spi_cs_n,
	input logic spi_mosi,
	output logic spi_miso,
	// word-addressed memory read port
	output logic [31:0] ram_addr,
	output logic ram_read_enable,
	input flash_emu_pkg::ram_word_t ram_read_data,
	input logic ram_read_valid
);

	spi_byte_if spi_bus [`FLASH_NUM_DEVICES-1:0] ();
	ram_req_if ram_req [`FLASH_NUM_DEVICES-1:0] ();

	spi_front_end u_front_end (
		.clk (clk),
		.reset (reset),
		.spi_sck (spi_sck),
		.spi_cs_n (spi_cs_n),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.bus (spi_bus)
	);

	// one read responder per chip select
	for (genvar i = 0; i < `FLASH_NUM_DEVICES; i++)
	begin : g_flash
		flash_read_responder u_responder (
			.clk (clk),
			.reset (reset),
			.bus (spi_bus[i]),
			.mem (ram_req[i])
		);
	end

	ram_port_arbiter u_arbiter (
		.clk (clk),
		.reset (reset),
		.req (ram_req),
		.ram_addr (ram_addr),
		.ram_read_enable (ram_read_enable),
		.ram_read_data (ram_read_data),
		.ram_read_valid (ram_read_valid)
	);

endmodule

// ==== verification/flash_emu_chk.sv ====
// reaches into u_arbiter for the grant and critical vectors, so the arbiter instance name must stay
`timescale 1ns/1ps
`include "flash_emu_cfg.svh"

module flash_emu_chk (
	input logic clk,
	input logic reset,
	input logic [`FLASH_NUM_DEVICES-1:0] grant,
	input logic [`FLASH_NUM_DEVICES-1:0] crit,
	input logic ram_read_enable,
	input logic ram_read_valid
);

	// at most one owner of the memory port
	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else $error("arbiter grant has more than one bit set");

	// a memory read only happens inside a locked read
	enable_needs_critical: assert property (@(posedge clk) disable iff (reset)
		ram_read_enable |-> (|crit))
		else $error("ram_read_enable high with no critical requester");

	// port is quiet right after reset
	quiet_after_reset: assert property (@(posedge clk) reset |=> (!ram_read_enable && !ram_read_valid))
		else $error("memory port active in the cycle after reset");

endmodule

bind flash_emu_top flash_emu_chk u_chk (
	.clk (clk),
	.reset (reset),
	.grant (u_arbiter.grant),
	.crit (u_arbiter.crit_v),
	.ram_read_enable (ram_read_enable),
	.ram_read_valid (ram_read_valid)
);

// ==== verification/flash_emu_tb.sv ====
// sck runs at 24 clk per period, memory latency stays within 1 to 16 clk, addresses wrap at 24 bits
`timescale 1ns/1ps
`include "flash_emu_cfg.svh"

module flash_emu_tb;

	// 4 reads in test 2, 3 in test 3, 1 command in test 4 and 40 in test 5
	localparam int num_tx = 48;
	// each transaction is 16 bytes at most, 8 bits of 24 clk at 8 ns, doubled for margin
	localparam longint watchdog_ns = longint'(num_tx) * 16 * 8 * 24 * 8 * 2;

	logic clk;
	logic reset;
	logic spi_sck;
	logic [`FLASH_NUM_DEVICES-1:0] spi_cs_n;
	logic spi_mosi;
	logic spi_miso;
	logic [31:0] ram_addr;
	logic ram_read_enable;
	flash_emu_pkg::ram_word_t ram_read_data;
	logic ram_read_valid;

	logic [31:0] rng_state = 32'd4;
	// sparse word memory, filled on first touch
	flash_emu_pkg::ram_word_t mem [logic [31:0]];
	int mem_latency;
	bit enable_seen;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int start_errors;
	flash_emu_pkg::byte_t op;

	flash_emu_top UUT (
		.clk (clk),
		.reset (reset),
		.spi_sck (spi_sck),
		.spi_cs_n (spi_cs_n),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.ram_addr (ram_addr),
		.ram_read_enable (ram_read_enable),
		.ram_read_data (ram_read_data),
		.ram_read_valid (ram_read_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(next_rand() % 32'(hi - lo + 1));
	endfunction

	// word contents hash the full word address, so access order does not matter
	function automatic flash_emu_pkg::ram_word_t mem_word(input logic [31:0] a);
		logic [31:0] h;
		if (!mem.exists(a))
		begin
			h = xorshift32(a ^ 32'h2545f491);
			mem[a] = h[31:16];
		end
		return mem[a];
	endfunction

	// byte k of a read, odd byte address takes the high half of the word
	function automatic flash_emu_pkg::byte_t expected_byte(input logic [23:0] start, input int k);
		logic [23:0] a;
		flash_emu_pkg::ram_word_t w;
		a = start + 24'(k);
		w = mem_word({9'd0, a[23:1]});
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	// memory answers after mem_latency clk and holds the data afterwards
	always
	begin : memory_model
		logic [31:0] req_addr;
		@(negedge clk);
		if (!reset && ram_read_enable)
		begin
			req_addr = ram_addr;
			repeat (mem_latency - 1) @(negedge clk);
			ram_read_data = mem_word(req_addr);
			ram_read_valid = 1'b1;
			@(negedge clk);
			ram_read_valid = 1'b0;
		end
	end

	always @(negedge clk)
	begin
		if (ram_read_enable)
			enable_seen = 1'b1;
	end

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before)
			tests_failed++;
		$display("test %s done with %0d errors", name, errors - err_before);
	endtask

	// mode 0 host, mosi set while sck is low and miso taken at the rising edge
	task automatic spi_transfer(input int dev, input flash_emu_pkg::byte_t tx_q[$],
		output flash_emu_pkg::byte_t rx_q[$]);
		flash_emu_pkg::byte_t rx;
		rx_q = {};
		@(negedge clk);
		spi_cs_n[dev] = 1'b0;
		repeat (12) @(negedge clk);
		foreach (tx_q[i])
		begin
			for (int b = 7; b >= 0; b--)
			begin
				spi_mosi = tx_q[i][b];
				repeat (12) @(negedge clk);
				rx[b] = spi_miso;
				spi_sck = 1'b1;
				repeat (12) @(negedge clk);
				spi_sck = 1'b0;
			end
			rx_q.push_back(rx);
		end
		repeat (12) @(negedge clk);
		spi_cs_n[dev] = 1'b1;
		// let the select release reach the arbiter
		repeat (24) @(negedge clk);
	endtask

	task automatic read_transaction(input int dev, input logic [23:0] addr, input int len);
		flash_emu_pkg::byte_t tx_q[$];
		flash_emu_pkg::byte_t rx_q[$];
		tx_q = {`FLASH_CMD_READ, addr[23:16], addr[15:8], addr[7:0]};
		for (int k = 0; k < len; k++)
			tx_q.push_back(flash_emu_pkg::byte_t'(next_rand()));
		mem_latency = rand_range(1, 16);
		spi_transfer(dev, tx_q, rx_q);
		// data starts after the opcode and three address bytes
		for (int k = 0; k < len; k++)
			check_value(rx_q[4 + k], expected_byte(addr, k),
				$sformatf("dev %0d addr %06h byte %0d", dev, addr, k));
	endtask

	task automatic unsupported_command(input int dev, input flash_emu_pkg::byte_t cmd, input int len);
		flash_emu_pkg::byte_t tx_q[$];
		flash_emu_pkg::byte_t rx_q[$];
		tx_q = {cmd};
		for (int k = 0; k < len + 3; k++)
			tx_q.push_back(flash_emu_pkg::byte_t'(next_rand()));
		enable_seen = 1'b0;
		spi_transfer(dev, tx_q, rx_q);
		foreach (rx_q[k])
			check_value(rx_q[k], `FLASH_IDLE_BYTE, $sformatf("opcode %02h byte %0d", cmd, k));
		check_value(enable_seen, 1'b0, "ram_read_enable during unsupported opcode");
	endtask

	initial
	begin
		#(watchdog_ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		spi_sck = 1'b0;
		spi_cs_n = '1;
		spi_mosi = 1'b0;
		ram_read_data = '0;
		ram_read_valid = 1'b0;
		mem_latency = 1;
		reset = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		// bus idle, nothing selected
		start_errors = errors;
		repeat (64)
		begin
			@(negedge clk);
			check_value(spi_miso, 1'b1, "spi_miso while idle");
			check_value(ram_read_enable, 1'b0, "ram_read_enable while idle");
		end
		report_test("idle after reset", start_errors);

		start_errors = errors;
		for (int d = 0; d < `FLASH_NUM_DEVICES; d++)
			read_transaction(d, 24'(next_rand()), rand_range(1, 12));
		report_test("single read per device", start_errors);

		// carries out of the low byte, the middle byte and the top of the space
		start_errors = errors;
		read_transaction(0, 24'h0000FF, 4);
		read_transaction(1, 24'h00FFFF, 4);
		read_transaction(2, 24'hFFFFFE, 4);
		report_test("address carry and wrap", start_errors);

		start_errors = errors;
		op = flash_emu_pkg::byte_t'(next_rand());
		if (op == `FLASH_CMD_READ)
			op = 8'h0B;
		unsupported_command(3, op, 6);
		report_test("unsupported opcode", start_errors);

		start_errors = errors;
		for (int t = 0; t < 40; t++)
			read_transaction(t % `FLASH_NUM_DEVICES, 24'(next_rand()), rand_range(1, 12));
		report_test("back-to-back random reads", start_errors);

		$display("tests %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/flash_emu_pkg.sv
rtl/spi_byte_if.sv
rtl/ram_req_if.sv
rtl/spi_front_end.sv
rtl/flash_read_responder.sv
rtl/ram_port_arbiter.sv
rtl/flash_emu_top.sv
verification/flash_emu_chk.sv
verification/flash_emu_tb.sv

// ==== Bender.yml ====
package:
  name: flash_emu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/flash_emu_pkg.sv
      - rtl/spi_byte_if.sv
      - rtl/ram_req_if.sv
      - rtl/spi_front_end.sv
      - rtl/flash_read_responder.sv
      - rtl/ram_port_arbiter.sv
      - rtl/flash_emu_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/flash_emu_chk.sv
      - verification/flash_emu_tb.sv
